//--- src/mem_space_settings.svh
/*
 Build-time settings of the memory space controller
 MS_RAM_WORDS must lie between 2 and 2**18 - 1, so the RAM fits one region
 MS_RAM_LATENCY must be at least 1
 CSR addresses are the low twelve bits of a CSR-region address
*/
`ifndef MEM_SPACE_SETTINGS_SVH
`define MEM_SPACE_SETTINGS_SVH

// ========================================
// RAM
// ========================================
// 32-bit words, 0x8000_0000 upwards
`define MS_RAM_WORDS 1024
// Strobe to ack, in clock cycles
`define MS_RAM_LATENCY 3

// ========================================
// Machine CSR indices
// ========================================
`define MS_CSR_MSCRATCH 12'h340
`define MS_CSR_MEPC     12'h341
`define MS_CSR_MCAUSE   12'h342
`define MS_CSR_MTVEC    12'h305

`endif

//--- src/mem_map_pkg.sv
/*
 Address map of the memory space
 Top twelve address bits select the region, the rest is the offset
 CSR region uses the low twelve bits as the CSR index
*/
package mem_map_pkg;

    // Region selected by an address
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_CSR,
        REGION_NONE
    } region_e;

    // Top twelve bits of each region
    localparam logic [11:0] RAM_REGION = 12'h800;
    localparam logic [11:0] CSR_REGION = 12'h400;

    // Region field over offset
    typedef struct packed {
        logic [11:0] region;
        logic [19:0] offset;
    } region_view_t;

    // Upper bits over CSR index
    typedef struct packed {
        logic [19:0] upper;
        logic [11:0] index;
    } csr_view_t;

    // One address word, two readings
    typedef union packed {
        region_view_t rgn;
        csr_view_t    csr;
    } mem_addr_u;

    // RAM only counts below its byte size, anything unmapped is REGION_NONE
    function automatic region_e decode_region(mem_addr_u addr, logic [19:0] ram_bytes);
        region_e result;
        if (addr.rgn.region == RAM_REGION && addr.rgn.offset < ram_bytes) begin
            result = REGION_RAM;
        end else if (addr.rgn.region == CSR_REGION) begin
            result = REGION_CSR;
        end else begin
            result = REGION_NONE;
        end
        return result;
    endfunction

endpackage

//--- src/bus_pkg.sv
/*
 Bundles of the strobe/acknowledge bus
 Requester side holds its request stable until ack or err
 Target side sees a one-cycle strobe and answers with a one-cycle ack or err
*/
package bus_pkg;

    // ========================================
    // Requester side
    // ========================================
    typedef struct packed {
        logic                   we;
        // Byte lanes, bit 0 is the low byte
        logic [3:0]             sel;
        mem_map_pkg::mem_addr_u addr;
        logic [31:0]            wdata;
    } mem_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] rdata;
    } mem_rsp_t;

    // ========================================
    // Target side
    // ========================================
    typedef struct packed {
        // One-cycle pulse, other fields hold until the response
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] addr;
        logic [31:0] wdata;
    } tgt_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] rdata;
    } tgt_rsp_t;

    // Requester that a target is working for
    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_CORE,
        OWNER_DATA
    } owner_e;

endpackage

//--- src/ram_target.sv
/*
 Behavioural word RAM with a fixed latency of MS_RAM_LATENCY cycles
 Access is performed on the strobe, the ack follows later
 No new strobe may arrive before the ack, and RAM never answers err
 Address bits above the word index are ignored
*/
`timescale 1ns/1ps
`include "mem_space_settings.svh"

module ram_target (
    input  logic              clk_i,
    input  logic              rst_i,
    input  bus_pkg::tgt_req_t req_i,
    output bus_pkg::tgt_rsp_t rsp_o
);
    localparam int IDX_W = $clog2(`MS_RAM_WORDS);
    localparam int CNT_W = $clog2(`MS_RAM_LATENCY + 1);

    logic [31:0]      mem_q [0:`MS_RAM_WORDS-1];
    logic [IDX_W-1:0] idx;
    logic [31:0]      rdata_q;
    // Cycles left until the ack
    logic [CNT_W-1:0] cnt_q;
    logic             ack_q;

    // Word index, byte offset dropped
    assign idx = req_i.addr[IDX_W+1:2];

    // ========================================
    // Storage
    // ========================================
    always_ff @(posedge clk_i) begin
        if (req_i.stb) begin
            if (req_i.we) begin
                // Only selected byte lanes change
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) begin
                        mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    // ========================================
    // Latency counter
    // ========================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (req_i.stb) begin
                cnt_q <= CNT_W'(`MS_RAM_LATENCY - 1);
                // Single-cycle RAM answers straight away
                ack_q <= (`MS_RAM_LATENCY == 1);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
                ack_q <= (cnt_q == CNT_W'(1));
            end
        end
    end

    assign rsp_o = '{ack: ack_q, err: 1'b0, rdata: rdata_q};

endmodule

//--- src/csr_file.sv
/*
 Machine CSRs mscratch, mepc, mcause and mtvec
 Every access is a full word, byte select has no effect
 Unknown index answers err and leaves all registers as they were
 Writes return the old value as read data
*/
`timescale 1ns/1ps
`include "mem_space_settings.svh"

module csr_file (
    input  logic              clk_i,
    input  logic              rst_i,
    input  bus_pkg::tgt_req_t req_i,
    output bus_pkg::tgt_rsp_t rsp_o
);
    import mem_map_pkg::*;
    import bus_pkg::*;

    mem_addr_u   addr;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtvec_q;
    logic [31:0] rd_word;
    logic        known;
    tgt_rsp_t    rsp_q;

    assign addr = req_i.addr;

    // Read mux and index check
    always_comb begin
        known = 1'b1;
        case (addr.csr.index)
            `MS_CSR_MSCRATCH: rd_word = mscratch_q;
            `MS_CSR_MEPC:     rd_word = mepc_q;
            `MS_CSR_MCAUSE:   rd_word = mcause_q;
            `MS_CSR_MTVEC:    rd_word = mtvec_q;
            default: begin
                rd_word = '0;
                known   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtvec_q    <= '0;
            rsp_q.ack  <= 1'b0;
            rsp_q.err  <= 1'b0;
        end else begin
            // One-cycle answer to every strobe
            rsp_q.ack <= req_i.stb & known;
            rsp_q.err <= req_i.stb & ~known;
            if (req_i.stb) begin
                rsp_q.rdata <= rd_word;
                if (req_i.we) begin
                    case (addr.csr.index)
                        `MS_CSR_MSCRATCH: mscratch_q <= req_i.wdata;
                        `MS_CSR_MEPC:     mepc_q     <= req_i.wdata;
                        `MS_CSR_MCAUSE:   mcause_q   <= req_i.wdata;
                        `MS_CSR_MTVEC:    mtvec_q    <= req_i.wdata;
                        default:          ;
                    endcase
                end
            end
        end
    end

    assign rsp_o = rsp_q;

endmodule

//--- src/mem_arbiter.sv
/*
 Arbiter and address decoder of the memory space
 A strobe is decided on the edge that samples it, or held until its target is free
 Data port wins a target that both ports want
 Core RAM accesses always go out as full-word reads
 Port rdata is only meaningful while ack or err is high
*/
`timescale 1ns/1ps
`include "mem_space_settings.svh"

module mem_arbiter (
    input  logic              clk_i,
    input  logic              rst_i,
    // Core requester
    input  logic              core_stb_i,
    input  bus_pkg::mem_req_t core_req_i,
    output bus_pkg::mem_rsp_t core_rsp_o,
    output logic              core_data_tag_o,
    // Data requester
    input  logic              data_stb_i,
    input  bus_pkg::mem_req_t data_req_i,
    output bus_pkg::mem_rsp_t data_rsp_o,
    // Targets
    output bus_pkg::tgt_req_t ram_req_o,
    input  bus_pkg::tgt_rsp_t ram_rsp_i,
    output bus_pkg::tgt_req_t csr_req_o,
    input  bus_pkg::tgt_rsp_t csr_rsp_i
);
    import mem_map_pkg::*;
    import bus_pkg::*;

    localparam logic [19:0] RAM_BYTES = 20'(`MS_RAM_WORDS * 4);

    // Requests that arrived but are not yet dispatched
    logic     core_stb_q;
    logic     data_stb_q;
    logic     core_act;
    logic     data_act;
    region_e  core_rgn;
    region_e  data_rgn;
    // Per-target state
    logic     ram_pend_q;
    logic     csr_pend_q;
    owner_e   ram_owner_q;
    owner_e   csr_owner_q;
    tgt_req_t ram_req_q;
    tgt_req_t csr_req_q;
    // Dispatch decisions for this edge
    logic     data_to_ram;
    logic     data_to_csr;
    logic     data_bad;
    logic     data_done;
    logic     core_to_ram;
    logic     core_to_csr;
    logic     core_bad;
    logic     core_done;
    // Port responses
    mem_rsp_t core_fin;
    mem_rsp_t data_fin;
    mem_rsp_t core_rsp_q;
    mem_rsp_t data_rsp_q;
    logic     core_tag_q;

    function automatic mem_rsp_t to_port(tgt_rsp_t rsp);
        return '{ack: rsp.ack, err: rsp.err, rdata: rsp.rdata};
    endfunction

    // ========================================
    // Decode and arbitration
    // ========================================
    assign core_act = core_stb_i | core_stb_q;
    assign data_act = data_stb_i | data_stb_q;
    assign core_rgn = decode_region(core_req_i.addr, RAM_BYTES);
    assign data_rgn = decode_region(data_req_i.addr, RAM_BYTES);

    assign data_to_ram = data_act && data_rgn == REGION_RAM && !ram_pend_q;
    assign data_to_csr = data_act && data_rgn == REGION_CSR && !csr_pend_q;
    assign data_bad    = data_act && data_rgn == REGION_NONE;
    assign data_done   = data_to_ram | data_to_csr | data_bad;

    // Core yields any target the data port is asking for, even a busy one
    assign core_to_ram = core_act && core_rgn == REGION_RAM && !ram_pend_q
                         && !(data_act && data_rgn == REGION_RAM);
    assign core_to_csr = core_act && core_rgn == REGION_CSR && !csr_pend_q
                         && !(data_act && data_rgn == REGION_CSR);
    assign core_bad    = core_act && core_rgn == REGION_NONE;
    assign core_done   = core_to_ram | core_to_csr | core_bad;

    // ========================================
    // Response routing
    // ========================================
    always_comb begin
        core_fin = '0;
        data_fin = '0;
        // Unmapped address, no target involved
        core_fin.err = core_bad;
        data_fin.err = data_bad;
        if (ram_rsp_i.ack | ram_rsp_i.err) begin
            if (ram_owner_q == OWNER_CORE) begin
                core_fin = to_port(ram_rsp_i);
            end else if (ram_owner_q == OWNER_DATA) begin
                data_fin = to_port(ram_rsp_i);
            end
        end
        if (csr_rsp_i.ack | csr_rsp_i.err) begin
            if (csr_owner_q == OWNER_CORE) begin
                core_fin = to_port(csr_rsp_i);
            end else if (csr_owner_q == OWNER_DATA) begin
                data_fin = to_port(csr_rsp_i);
            end
        end
    end

    // ========================================
    // State
    // ========================================
    always_ff @(posedge clk_i) begin
        // Read data and tag follow the routed response
        core_rsp_q.rdata <= core_fin.rdata;
        data_rsp_q.rdata <= data_fin.rdata;
        core_tag_q       <= &core_fin.rdata[1:0];

        if (rst_i) begin
            core_stb_q     <= 1'b0;
            data_stb_q     <= 1'b0;
            ram_pend_q     <= 1'b0;
            csr_pend_q     <= 1'b0;
            ram_owner_q    <= OWNER_NONE;
            csr_owner_q    <= OWNER_NONE;
            ram_req_q.stb  <= 1'b0;
            csr_req_q.stb  <= 1'b0;
            core_rsp_q.ack <= 1'b0;
            core_rsp_q.err <= 1'b0;
            data_rsp_q.ack <= 1'b0;
            data_rsp_q.err <= 1'b0;
        end else begin
            core_stb_q     <= core_act & ~core_done;
            data_stb_q     <= data_act & ~data_done;
            ram_req_q.stb  <= 1'b0;
            csr_req_q.stb  <= 1'b0;
            core_rsp_q.ack <= core_fin.ack;
            core_rsp_q.err <= core_fin.err;
            data_rsp_q.ack <= data_fin.ack;
            data_rsp_q.err <= data_fin.err;

            // Target done, free on the next edge
            if (ram_rsp_i.ack | ram_rsp_i.err) begin
                ram_pend_q  <= 1'b0;
                ram_owner_q <= OWNER_NONE;
            end
            if (csr_rsp_i.ack | csr_rsp_i.err) begin
                csr_pend_q  <= 1'b0;
                csr_owner_q <= OWNER_NONE;
            end

            // RAM dispatch
            if (data_to_ram) begin
                ram_req_q   <= '{stb: 1'b1, we: data_req_i.we, sel: data_req_i.sel,
                                 addr: data_req_i.addr, wdata: data_req_i.wdata};
                ram_pend_q  <= 1'b1;
                ram_owner_q <= OWNER_DATA;
            end else if (core_to_ram) begin
                // Instruction fetch, full word
                ram_req_q   <= '{stb: 1'b1, we: 1'b0, sel: 4'b1111,
                                 addr: core_req_i.addr, wdata: '0};
                ram_pend_q  <= 1'b1;
                ram_owner_q <= OWNER_CORE;
            end

            // CSR dispatch
            if (data_to_csr) begin
                csr_req_q   <= '{stb: 1'b1, we: data_req_i.we, sel: data_req_i.sel,
                                 addr: data_req_i.addr, wdata: data_req_i.wdata};
                csr_pend_q  <= 1'b1;
                csr_owner_q <= OWNER_DATA;
            end else if (core_to_csr) begin
                csr_req_q   <= '{stb: 1'b1, we: core_req_i.we, sel: core_req_i.sel,
                                 addr: core_req_i.addr, wdata: core_req_i.wdata};
                csr_pend_q  <= 1'b1;
                csr_owner_q <= OWNER_CORE;
            end
        end
    end

    assign ram_req_o       = ram_req_q;
    assign csr_req_o       = csr_req_q;
    assign core_rsp_o      = core_rsp_q;
    assign data_rsp_o      = data_rsp_q;
    // Full-length instruction marker
    assign core_data_tag_o = core_tag_q;

endmodule

//--- src/mem_space.sv
/*
 Memory space controller with a core port and a data port
 One transaction outstanding per port, data port wins on a tie
 RAM and CSR accesses may be in flight together
*/
`timescale 1ns/1ps

module mem_space (
    input  logic              clk_i,
    input  logic              rst_i,
    // Instruction fetch and CSR access
    input  logic              core_stb_i,
    input  bus_pkg::mem_req_t core_req_i,
    output bus_pkg::mem_rsp_t core_rsp_o,
    output logic              core_data_tag_o,
    // Loads and stores from execute
    input  logic              data_stb_i,
    input  bus_pkg::mem_req_t data_req_i,
    output bus_pkg::mem_rsp_t data_rsp_o
);
    import bus_pkg::*;

    // Arbiter to target buses
    tgt_req_t ram_req;
    tgt_rsp_t ram_rsp;
    tgt_req_t csr_req;
    tgt_rsp_t csr_rsp;

    // ========================================
    // Arbiter
    // ========================================
    mem_arbiter u_arbiter (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .core_stb_i      (core_stb_i),
        .core_req_i      (core_req_i),
        .core_rsp_o      (core_rsp_o),
        .core_data_tag_o (core_data_tag_o),
        .data_stb_i      (data_stb_i),
        .data_req_i      (data_req_i),
        .data_rsp_o      (data_rsp_o),
        .ram_req_o       (ram_req),
        .ram_rsp_i       (ram_rsp),
        .csr_req_o       (csr_req),
        .csr_rsp_i       (csr_rsp)
    );

    // ========================================
    // Targets
    // ========================================
    ram_target u_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    csr_file u_csr (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (csr_req),
        .rsp_o (csr_rsp)
    );

endmodule

//--- tb/tb_mem_space_ref.svh
/*
 Reference model of the memory space, included inside the testbench module
 Shadow state changes when a request is issued, so calls must follow dispatch order
 Only RAM words that were fully written before are read back
*/
`ifndef TB_MEM_SPACE_REF_SVH
`define TB_MEM_SPACE_REF_SVH

// Expected response of one transaction
typedef struct packed {
    logic        err;
    logic        chk_data;
    logic        chk_tag;
    logic [31:0] rdata;
} expect_t;

logic [31:0] shadow_ram [0:`MS_RAM_WORDS-1];
// mscratch, mepc, mcause, mtvec
logic [31:0] shadow_csr [0:3];

// Shadow slot of a CSR index, -1 if the CSR does not exist
function automatic int csr_slot(input logic [11:0] index);
    case (index)
        `MS_CSR_MSCRATCH: return 0;
        `MS_CSR_MEPC:     return 1;
        `MS_CSR_MCAUSE:   return 2;
        `MS_CSR_MTVEC:    return 3;
        default:          return -1;
    endcase
endfunction

// Expected response, shadow state updated on the way
function automatic expect_t predict(input logic is_data, input logic we, input logic [3:0] sel,
                                    input logic [31:0] addr, input logic [31:0] wdata);
    expect_t     want;
    int          slot;
    int unsigned word;
    want = '0;
    slot = csr_slot(addr[11:0]);
    word = addr[19:2];
    if (addr[31:20] == 12'h800 && addr[19:0] < `MS_RAM_WORDS * 4) begin
        // Core side only fetches, a core write turns into a read
        if (we && is_data) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    shadow_ram[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else begin
            want.chk_data = 1'b1;
            want.rdata    = shadow_ram[word];
        end
    end else if (addr[31:20] == 12'h400 && slot >= 0) begin
        // Full word, byte select has no effect
        if (we) begin
            shadow_csr[slot] = wdata;
        end else begin
            want.chk_data = 1'b1;
            want.rdata    = shadow_csr[slot];
        end
    end else begin
        want.err = 1'b1;
    end
    want.chk_tag = !is_data && want.chk_data;
    return want;
endfunction

`endif

//--- tb/tb_mem_space.sv
/*
 Self-checking testbench of the memory space controller
 Inputs change on the falling edge, responses are checked on the falling edge
 One transaction per port in flight, the next one starts after all answers
*/
`timescale 1ns/1ps
`include "mem_space_settings.svh"

module tb_mem_space;
    import bus_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic     clk_i;
    logic     rst_i;
    logic     core_stb;
    mem_req_t core_req;
    mem_rsp_t core_rsp;
    logic     core_tag;
    logic     data_stb;
    mem_req_t data_req;
    mem_rsp_t data_rsp;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     test_errors = 0;
    string  test_name = "startup";
    // Rising edges since time zero, and the edge of each port's last answer
    int     cycle = 0;
    int     core_done_cycle = 0;
    int     data_done_cycle = 0;

    `include "tb_mem_space_ref.svh"

    // Expectations waiting for their response
    expect_t core_exp_q [$];
    expect_t data_exp_q [$];

    mem_space DUT (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .core_stb_i      (core_stb),
        .core_req_i      (core_req),
        .core_rsp_o      (core_rsp),
        .core_data_tag_o (core_tag),
        .data_stb_i      (data_stb),
        .data_req_i      (data_req),
        .data_rsp_o      (data_rsp)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle++;
    end

    // ========================================
    // Checking
    // ========================================
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, name, expected, actual);
        end
    endtask

    task automatic compare_rsp(input string port, input expect_t want, input mem_rsp_t rsp,
                               input logic tag);
        // ack and err as a pair with exactly one of them set
        check({port, " ack/err"}, 32'({!want.err, want.err}), 32'({rsp.ack, rsp.err}));
        if (want.chk_data) begin
            check({port, " rdata"}, want.rdata, rsp.rdata);
        end
        // Full-length instruction has both low bits set
        if (want.chk_tag) begin
            check({port, " tag"}, 32'(&want.rdata[1:0]), 32'(tag));
        end
    endtask

    // Every response pulse is matched against the oldest expectation of its port
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (core_rsp.ack || core_rsp.err) begin
                core_done_cycle = cycle;
                if (core_exp_q.size() == 0) begin
                    errors++;
                    $display("%s: core port answered with no request outstanding", test_name);
                end else begin
                    compare_rsp("core", core_exp_q.pop_front(), core_rsp, core_tag);
                end
            end
            if (data_rsp.ack || data_rsp.err) begin
                data_done_cycle = cycle;
                if (data_exp_q.size() == 0) begin
                    errors++;
                    $display("%s: data port answered with no request outstanding", test_name);
                end else begin
                    compare_rsp("data", data_exp_q.pop_front(), data_rsp, 1'b0);
                end
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    function automatic logic [31:0] word_addr(input int unsigned index);
        return 32'h8000_0000 + (index << 2);
    endfunction

    function automatic logic [31:0] csr_addr(input logic [11:0] index);
        return {12'h400, 8'h00, index};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s: %s", test_name, reason);
        $display("=== FAIL ===");
        $finish;
    endtask

    // Raise a strobe while on a falling edge
    task automatic start(input logic is_data, input logic we, input logic [3:0] sel,
                         input logic [31:0] addr, input logic [31:0] wdata);
        mem_req_t req;
        expect_t  want;
        req  = {we, sel, addr, wdata};
        want = predict(is_data, we, sel, addr, wdata);
        if (is_data) begin
            data_req = req;
            data_stb = 1'b1;
            data_exp_q.push_back(want);
        end else begin
            core_req = req;
            core_stb = 1'b1;
            core_exp_q.push_back(want);
        end
    endtask

    // Drop the strobes and wait until every started transaction has answered
    task automatic finish_burst();
        int waited;
        waited = 0;
        @(negedge clk_i);
        core_stb = 1'b0;
        data_stb = 1'b0;
        while ((core_exp_q.size() != 0 || data_exp_q.size() != 0) && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (core_exp_q.size() != 0 || data_exp_q.size() != 0) begin
            abort_run("no response arrived within the time limit");
        end
    endtask

    task automatic access(input logic is_data, input logic we, input logic [3:0] sel,
                          input logic [31:0] addr, input logic [31:0] wdata);
        @(negedge clk_i);
        start(is_data, we, sel, addr, wdata);
        finish_burst();
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %s passed", test_name);
        end else begin
            $display("test %s failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int          idx [8];
        logic [31:0] word;
        logic [11:0] csr_idx [4];
        logic [31:0] bad_addr [5];
        seed     = 32'h56e6;
        clk_i    = 1'b0;
        rst_i    = 1'b1;
        core_stb = 1'b0;
        data_stb = 1'b0;
        core_req = '0;
        data_req = '0;
        csr_idx  = '{`MS_CSR_MSCRATCH, `MS_CSR_MEPC, `MS_CSR_MCAUSE, `MS_CSR_MTVEC};
        // Unmapped, then just past the RAM, then a near miss on the CSR region
        bad_addr = '{32'h0000_0000, 32'h1234_5678, word_addr(`MS_RAM_WORDS),
                     32'h800F_FFFC, 32'h4010_0340};
        repeat (9) @(negedge clk_i);

        begin_test("reset");
        // Reset still held, both ports must already be quiet
        check("core ack/err in reset", 32'h0, 32'({core_rsp.ack, core_rsp.err}));
        check("data ack/err in reset", 32'h0, 32'({data_rsp.ack, data_rsp.err}));
        @(negedge clk_i);
        rst_i = 1'b0;
        repeat (3) begin
            @(negedge clk_i);
            check("core ack/err", 32'h0, 32'({core_rsp.ack, core_rsp.err}));
            check("data ack/err", 32'h0, 32'({data_rsp.ack, data_rsp.err}));
        end
        end_test();

        // Full words first so that no lane stays unknown
        begin_test("data ram");
        for (int i = 0; i < 8; i++) begin
            idx[i] = $unsigned($random(seed)) % `MS_RAM_WORDS;
            access(1'b1, 1'b1, 4'hf, word_addr(idx[i]), $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            access(1'b1, 1'b1, 4'($random(seed)), word_addr(idx[i]), $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            access(1'b1, 1'b0, 4'hf, word_addr(idx[i]), 32'h0);
        end
        end_test();

        // Low bits walk through all four patterns
        begin_test("core fetch");
        for (int i = 0; i < 8; i++) begin
            word      = $random(seed);
            word[1:0] = i[1:0];
            access(1'b1, 1'b1, 4'hf, word_addr(16 + i), word);
        end
        for (int i = 0; i < 8; i++) begin
            access(1'b0, 1'b0, 4'($random(seed)), word_addr(16 + i), 32'h0);
        end
        // Core write becomes a fetch
        access(1'b0, 1'b1, 4'hf, word_addr(16), 32'hdead_beef);
        access(1'b1, 1'b0, 4'hf, word_addr(16), 32'h0);
        end_test();

        begin_test("csr");
        for (int i = 0; i < 4; i++) begin
            access(1'b1, 1'b1, 4'hf, csr_addr(csr_idx[i]), $random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 1'b0, 4'hf, csr_addr(csr_idx[i]), 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 1'b1, 4'h1, csr_addr(csr_idx[i]), $random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            access(1'b1, 1'b0, 4'h2, csr_addr(csr_idx[i]), 32'h0);
        end
        // Unknown index and then proof that nothing moved
        access(1'b1, 1'b1, 4'hf, csr_addr(12'h7c0), 32'h1234_5678);
        access(1'b0, 1'b1, 4'hf, csr_addr(12'h300), 32'h8765_4321);
        access(1'b0, 1'b0, 4'hf, csr_addr(12'h343), 32'h0);
        for (int i = 0; i < 4; i++) begin
            access(1'b1, 1'b0, 4'hf, csr_addr(csr_idx[i]), 32'h0);
        end
        end_test();

        begin_test("invalid");
        for (int i = 0; i < 5; i++) begin
            access(1'b0, 1'b0, 4'hf, bad_addr[i], 32'h0);
            access(1'b1, 1'b1, 4'hf, bad_addr[i], $random(seed));
        end
        end_test();

        // Data side is predicted first since it wins a shared target
        begin_test("simultaneous");
        @(negedge clk_i);
        start(1'b1, 1'b1, 4'hf, word_addr(40), 32'h1357_9bdf);
        start(1'b0, 1'b0, 4'hf, word_addr(40), 32'h0);
        finish_burst();
        check("ram order", 32'h1, 32'(data_done_cycle <= core_done_cycle));
        @(negedge clk_i);
        start(1'b1, 1'b0, 4'hf, word_addr(40), 32'h0);
        start(1'b0, 1'b0, 4'hf, csr_addr(`MS_CSR_MEPC), 32'h0);
        finish_burst();
        @(negedge clk_i);
        start(1'b1, 1'b1, 4'hf, csr_addr(`MS_CSR_MTVEC), $random(seed));
        start(1'b0, 1'b0, 4'hf, csr_addr(`MS_CSR_MTVEC), 32'h0);
        finish_burst();
        check("csr order", 32'h1, 32'(data_done_cycle <= core_done_cycle));
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- mem_space.f
+incdir+src
+incdir+tb
src/mem_map_pkg.sv
src/bus_pkg.sv
src/ram_target.sv
src/csr_file.sv
src/mem_arbiter.sv
src/mem_space.sv
tb/tb_mem_space.sv

//--- Bender.yml
package:
  name: mem_space

sources:
  # Design, packages first
  - include_dirs:
      - src
    files:
      - src/mem_map_pkg.sv
      - src/bus_pkg.sv
      - src/ram_target.sv
      - src/csr_file.sv
      - src/mem_arbiter.sv
      - src/mem_space.sv
  # Testbench, top module tb_mem_space
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/tb_mem_space.sv
